// File: source/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

    // horizontal mode, in pixel clocks
    parameter int H_VISIBLE     = 64;           // active pixels per line
    parameter int H_FRONT_PORCH = 4;            // blank before sync
    parameter int H_SYNC_PULSE  = 8;            // sync width
    parameter int H_BACK_PORCH  = 12;           // blank after sync

    // vertical mode, in lines
    parameter int V_VISIBLE     = 32;           // active lines per frame
    parameter int V_FRONT_PORCH = 2;
    parameter int V_SYNC_PULSE  = 2;
    parameter int V_BACK_PORCH  = 4;

    // active level of the sync outputs
    parameter logic H_SYNC_POLARITY = 1'b0;     // active low
    parameter logic V_SYNC_POLARITY = 1'b0;     // active low

    typedef logic [10:0] count_t;               // pixel or line counter

    // regions in scan order, horizontal visible comes last in a line
    typedef enum logic [1:0] {
        SYNC_PRE     = 2'b00,                   // front porch
        SYNC_PULSE   = 2'b01,                   // sync active
        SYNC_POST    = 2'b10,                   // back porch
        SYNC_VISIBLE = 2'b11                    // active video
    } sync_state_e;

    // beam status shared by all display blocks
    typedef struct packed {
        logic hsync;                            // raw sync, active high
        logic vsync;
        logic visible;                          // both axes visible
        logic line_end;                         // last pixel of line strobe
        logic frame_end;                        // last pixel of frame strobe
        logic fetch;                            // inside memory fetch window
        logic fetch_start;                      // fetch window about to open
    } beam_t;

endpackage

`default_nettype wire

// File: source/text_mode_pkg.sv
`default_nettype none

package text_mode_pkg;

    typedef logic [15:0] vram_addr_t;           // video RAM word address
    typedef logic [15:0] vram_word_t;           // attr in [15:8], char code in [7:0]
    typedef logic [12:0] font_addr_t;           // font RAM byte address
    typedef logic [7:0]  glyph_row_t;           // one row of a glyph, msb leftmost
    typedef logic [7:0]  attr_t;                // bg in [7:4], fg in [3:0]
    typedef logic [3:0]  color_idx_t;           // palette index
    typedef logic [11:0] rgb_t;                 // 4 bits each of r, g, b

    // one text pixel on its way to the colour stage
    typedef struct packed {
        logic       on;                         // glyph bit
        color_idx_t fg;                         // foreground index
        color_idx_t bg;                         // background index
        logic       enable;                     // display enable, frame latched
    } text_pix_t;

    // fixed IRGB palette
    parameter rgb_t DEFAULT_PALETTE [16] = '{
        12'h000,                                // black
        12'h00A,                                // blue
        12'h0A0,                                // green
        12'h0AA,                                // cyan
        12'hA00,                                // red
        12'hA0A,                                // magenta
        12'hAA0,                                // brown
        12'hAAA,                                // light gray
        12'h555,                                // dark gray
        12'h55F,                                // light blue
        12'h5F5,                                // light green
        12'h5FF,                                // light cyan
        12'hF55,                                // light red
        12'hF5F,                                // light magenta
        12'hFF5,                                // yellow
        12'hFFF                                 // white
    };

endpackage

`default_nettype wire

// File: source/video_timing.sv
`default_nettype none
`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE     = video_timing_pkg::H_VISIBLE,
    parameter int H_FRONT_PORCH = video_timing_pkg::H_FRONT_PORCH,
    parameter int H_SYNC_PULSE  = video_timing_pkg::H_SYNC_PULSE,
    parameter int H_BACK_PORCH  = video_timing_pkg::H_BACK_PORCH,
    parameter int V_VISIBLE     = video_timing_pkg::V_VISIBLE,
    parameter int V_FRONT_PORCH = video_timing_pkg::V_FRONT_PORCH,
    parameter int V_SYNC_PULSE  = video_timing_pkg::V_SYNC_PULSE,
    parameter int V_BACK_PORCH  = video_timing_pkg::V_BACK_PORCH
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    output video_timing_pkg::beam_t beam_o
);
    import video_timing_pkg::*;

    localparam int H_OFFSCREEN = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int H_TOTAL     = H_OFFSCREEN + H_VISIBLE;
    localparam int V_TOTAL     = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    // fetch runs one character ahead of the pixels it feeds
    localparam count_t FETCH_BEGIN = count_t'(H_OFFSCREEN - 9);
    localparam count_t FETCH_END   = count_t'(H_TOTAL - 9);

    sync_state_e h_state, h_state_next;
    sync_state_e v_state, v_state_next;
    count_t      h_count, h_count_next, h_region_end;
    count_t      v_count, v_count_next, v_region_end;
    logic        fetch, fetch_next, fetch_toggle;
    logic        line_end, frame_end;

    always_comb begin
        // blanking sits left of the visible pixels
        unique case (h_state)
            SYNC_PRE:     h_region_end = count_t'(H_FRONT_PORCH - 1);
            SYNC_PULSE:   h_region_end = count_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            SYNC_POST:    h_region_end = count_t'(H_OFFSCREEN - 1);
            default:      h_region_end = count_t'(H_TOTAL - 1);
        endcase
        // visible lines first, blanking at the bottom
        unique case (v_state)
            SYNC_VISIBLE: v_region_end = count_t'(V_VISIBLE - 1);
            SYNC_PRE:     v_region_end = count_t'(V_VISIBLE + V_FRONT_PORCH - 1);
            SYNC_PULSE:   v_region_end = count_t'(V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            default:      v_region_end = count_t'(V_TOTAL - 1);
        endcase

        line_end  = (h_state == SYNC_VISIBLE) && (h_count == h_region_end);
        frame_end = line_end && (v_state == SYNC_POST) && (v_count == v_region_end);

        h_state_next = h_state;
        if (h_count == h_region_end) begin
            h_state_next = sync_state_e'(h_state + 2'd1);    // wraps visible -> pre
        end
        v_state_next = v_state;
        if (line_end && (v_count == v_region_end)) begin
            v_state_next = sync_state_e'(v_state + 2'd1);
        end

        h_count_next = line_end ? '0 : h_count + count_t'(1);
        v_count_next = v_count;
        if (line_end) begin
            v_count_next = frame_end ? '0 : v_count + count_t'(1);
        end

        // window edges only flip the level on visible lines
        fetch_toggle = (v_state == SYNC_VISIBLE)
                    && (h_count == (fetch ? FETCH_END : FETCH_BEGIN));
        fetch_next   = fetch ^ fetch_toggle;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= SYNC_PRE;                 // start of a line
            v_state <= SYNC_VISIBLE;             // top of a frame
            h_count <= '0;
            v_count <= '0;
            fetch   <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
            fetch   <= fetch_next;
        end
    end

    always_comb begin
        beam_o.hsync       = (h_state == SYNC_PULSE);
        beam_o.vsync       = (v_state == SYNC_PULSE);
        beam_o.visible     = (h_state == SYNC_VISIBLE) && (v_state == SYNC_VISIBLE);
        beam_o.line_end    = line_end;
        beam_o.frame_end   = frame_end;
        beam_o.fetch       = fetch;
        beam_o.fetch_start = fetch_toggle && !fetch;   // rising edge of the window
    end

endmodule

`default_nettype wire

// File: source/text_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module text_fetch #(
    parameter int CHARS_WIDE  = 8,
    parameter int FONT_HEIGHT = 8
) (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      enable_i,
    input  wire video_timing_pkg::beam_t   beam_i,
    input  wire text_mode_pkg::vram_word_t vram_data_i,
    input  wire text_mode_pkg::glyph_row_t fontram_data_i,
    output text_mode_pkg::vram_addr_t      vram_addr_o,
    output logic                           vram_sel_o,
    output text_mode_pkg::font_addr_t      fontram_addr_o,
    output logic                           fontram_sel_o,
    output logic                           blit_cycle_o,
    output text_mode_pkg::text_pix_t       pix_o
);
    import text_mode_pkg::*;

    localparam logic [3:0] LAST_ROW  = 4'(FONT_HEIGHT - 1);
    localparam vram_addr_t ROW_WORDS = vram_addr_t'(CHARS_WIDE);

    logic [2:0] char_x;                          // column inside the cell, paces memory slots
    logic [3:0] cell_row;                        // glyph row inside the cell
    vram_addr_t text_addr;                       // next cell to read
    vram_addr_t line_addr;                       // first cell of current text row
    logic       disp_en;                         // enable_i sampled at frame end
    logic       fetching;

    glyph_row_t glyph_shift;                     // pixels of current cell, msb out first
    attr_t      attr;                            // colours of current cell
    attr_t      attr_next;                       // colours of cell being fetched

    assign fetching = disp_en && beam_i.fetch;

    // font row follows the char code straight off the vram bus
    assign fontram_addr_o = {1'b0, vram_data_i[7:0], cell_row};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            char_x        <= '0;
            cell_row      <= '0;
            text_addr     <= '0;
            line_addr     <= '0;
            disp_en       <= 1'b0;
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            blit_cycle_o  <= 1'b0;
        end else begin
            vram_sel_o    <= 1'b0;               // single-cycle selects
            fontram_sel_o <= 1'b0;
            blit_cycle_o  <= 1'b1;               // blitter owns memory outside the window

            char_x <= beam_i.fetch_start ? 3'd0 : char_x + 3'd1;

            if (fetching) begin
                blit_cycle_o <= char_x[1];       // video and blitter alternate in pairs
                case (char_x)
                    3'd4: vram_sel_o    <= 1'b1; // read in column 5, address already out
                    3'd5: fontram_sel_o <= 1'b1; // char code valid in column 6
                    3'd7: text_addr     <= text_addr + vram_addr_t'(1);
                    default: ;
                endcase
            end

            if (beam_i.line_end) begin
                if (cell_row == LAST_ROW) begin
                    cell_row  <= '0;              // move down one text row
                    line_addr <= line_addr + ROW_WORDS;
                    text_addr <= line_addr + ROW_WORDS;
                end else begin
                    cell_row  <= cell_row + 4'd1;
                    text_addr <= line_addr;       // same cells again
                end
            end

            // frame end wins over the line end it coincides with
            if (beam_i.frame_end) begin
                cell_row  <= '0;
                text_addr <= '0;
                line_addr <= '0;
                disp_en   <= enable_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        glyph_shift <= {glyph_shift[6:0], 1'b0};        // one pixel per clock
        if (fetching) begin
            case (char_x)
                3'd4: vram_addr_o <= text_addr;
                3'd6: attr_next   <= vram_data_i[15:8];
                3'd7: begin
                    glyph_shift <= fontram_data_i;      // next cell starts on the following clock
                    attr        <= attr_next;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        pix_o.on     = glyph_shift[7];
        pix_o.fg     = attr[3:0];
        pix_o.bg     = attr[7:4];
        pix_o.enable = disp_en;
    end

endmodule

`default_nettype wire

// File: source/pixel_out.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_out #(
    parameter logic H_SYNC_POLARITY = video_timing_pkg::H_SYNC_POLARITY,
    parameter logic V_SYNC_POLARITY = video_timing_pkg::V_SYNC_POLARITY
) (
    input  wire logic                     clk,
    input  wire logic                     reset_i,
    input  wire video_timing_pkg::beam_t  beam_i,
    input  wire text_mode_pkg::text_pix_t pix_i,
    output logic [3:0]                    red_o,
    output logic [3:0]                    green_o,
    output logic [3:0]                    blue_o,
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          visible_o
);
    import text_mode_pkg::*;

    logic       show;                            // pixel is on screen and display is on
    color_idx_t color_idx;
    rgb_t       rgb;

    always_comb begin
        show      = beam_i.visible && pix_i.enable;
        color_idx = pix_i.on ? pix_i.fg : pix_i.bg;
        // blanking must be black for the monitor's black level
        rgb       = show ? DEFAULT_PALETTE[color_idx] : '0;
    end

    // colour, syncs and visible leave on the same edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            red_o     <= '0;
            green_o   <= '0;
            blue_o    <= '0;
            hsync_o   <= ~H_SYNC_POLARITY;       // inactive level
            vsync_o   <= ~V_SYNC_POLARITY;
            visible_o <= 1'b0;
        end else begin
            red_o     <= rgb[11:8];
            green_o   <= rgb[7:4];
            blue_o    <= rgb[3:0];
            hsync_o   <= beam_i.hsync ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o   <= beam_i.vsync ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            visible_o <= show;
        end
    end

endmodule

`default_nettype wire

// File: source/video_gen.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      enable_i,        // display on, applied at frame end
    output logic                           blit_cycle_o,    // 1 when memory is free for the blitter
    output logic                           fontram_sel_o,
    output text_mode_pkg::font_addr_t      fontram_addr_o,
    input  wire text_mode_pkg::glyph_row_t fontram_data_i,
    output logic                           vram_sel_o,
    output text_mode_pkg::vram_addr_t      vram_addr_o,
    input  wire text_mode_pkg::vram_word_t vram_data_i,
    output logic [3:0]                     red_o,
    output logic [3:0]                     green_o,
    output logic [3:0]                     blue_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           visible_o
);
    import video_timing_pkg::*;
    import text_mode_pkg::*;

    localparam int CELL_WIDTH  = 8;              // glyph rows are one byte
    localparam int CHARS_WIDE  = H_VISIBLE / CELL_WIDTH;
    localparam int FONT_HEIGHT = 8;

    beam_t     beam;                             // shared beam status
    text_pix_t text_pix;                         // text pixel into the colour stage

    video_timing #(
        .H_VISIBLE     (H_VISIBLE),
        .H_FRONT_PORCH (H_FRONT_PORCH),
        .H_SYNC_PULSE  (H_SYNC_PULSE),
        .H_BACK_PORCH  (H_BACK_PORCH),
        .V_VISIBLE     (V_VISIBLE),
        .V_FRONT_PORCH (V_FRONT_PORCH),
        .V_SYNC_PULSE  (V_SYNC_PULSE),
        .V_BACK_PORCH  (V_BACK_PORCH)
    ) u_timing (
        .clk     (clk),
        .reset_i (reset_i),
        .beam_o  (beam)
    );

    text_fetch #(
        .CHARS_WIDE  (CHARS_WIDE),
        .FONT_HEIGHT (FONT_HEIGHT)
    ) u_text (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .beam_i         (beam),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_addr_o    (vram_addr_o),
        .vram_sel_o     (vram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .blit_cycle_o   (blit_cycle_o),
        .pix_o          (text_pix)
    );

    pixel_out #(
        .H_SYNC_POLARITY (H_SYNC_POLARITY),
        .V_SYNC_POLARITY (V_SYNC_POLARITY)
    ) u_pixel (
        .clk       (clk),
        .reset_i   (reset_i),
        .beam_i    (beam),
        .pix_i     (text_pix),
        .red_o     (red_o),
        .green_o   (green_o),
        .blue_o    (blue_o),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .visible_o (visible_o)
    );

endmodule

`default_nettype wire

// File: dv/video_gen_chk.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen_chk (
    input wire logic        clk,
    input wire logic        reset_i,
    input wire logic        hsync_i,
    input wire logic        visible_i,
    input wire logic [11:0] rgb_i,           // red, green, blue nibbles
    input wire logic        vram_sel_i,
    input wire logic        blit_cycle_i
);
    import video_timing_pkg::*;

    logic hs_active;

    assign hs_active = (hsync_i == H_SYNC_POLARITY);

    // sync pulse holds for the whole sync region, then releases
    a_hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        $rose(hs_active) |-> hs_active [*H_SYNC_PULSE] ##1 !hs_active)
        else $error("hsync pulse width differs from %0d clocks", H_SYNC_PULSE);

    a_blank_black: assert property (@(posedge clk) disable iff (reset_i)
        !visible_i |-> (rgb_i == '0))
        else $error("colour not black while visible_o is low");

    // video RAM reads only in video-owned slots
    a_sel_in_video_slot: assert property (@(posedge clk) disable iff (reset_i)
        $rose(vram_sel_i) |-> !blit_cycle_i)
        else $error("vram_sel_o rose while blit_cycle_o was high");

endmodule

bind video_gen video_gen_chk chk (
    .clk           (clk),
    .reset_i       (reset_i),
    .hsync_i       (hsync_o),
    .visible_i     (visible_o),
    .rgb_i         ({red_o, green_o, blue_o}),
    .vram_sel_i    (vram_sel_o),
    .blit_cycle_i  (blit_cycle_o)
);

`default_nettype wire

// File: dv/video_gen_tb.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen_tb;
    import text_mode_pkg::*;

    localparam int LINE_CLKS = 88;
    localparam int FRAME_CLKS = LINE_CLKS * 40;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CLKS + 200;

    logic clk = 1'b0;
    logic reset_i, enable_i;
    logic blit_cycle_o, fontram_sel_o, vram_sel_o;
    font_addr_t fontram_addr_o;
    glyph_row_t fontram_data_i = '0;
    vram_addr_t vram_addr_o;
    vram_word_t vram_data_i = '0;
    logic [3:0] red_o, green_o, blue_o;
    logic hsync_o, vsync_o, visible_o;

    vram_word_t vram [0:63];                     // 8 x 4 text cells live in the low words
    glyph_row_t font [0:8191];
    logic [7:0] lfsr_state = 8'd81;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    video_gen dut (.*);

    always #2 clk = ~clk;                        // 4 ns period

    // registered reads, data held until the next select
    always @(posedge clk) begin
        if (vram_sel_o) vram_data_i <= vram[vram_addr_o[5:0]];
        if (fontram_sel_o) fontram_data_i <= font[fontram_addr_o];
    end

    // taps 8 6 5 4
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[6:0],
                          lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3]};
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errs);
        end
    endtask

    // expected colour of visible pixel x on visible line y
    function automatic logic [11:0] ref_color(input int x, input int y);
        vram_word_t word;
        glyph_row_t row;
        logic [3:0] idx;
        word = vram[(y / 8) * 8 + x / 8];
        row = font[{1'b0, word[7:0], 4'(y % 8)}];
        idx = row[7 - x % 8] ? word[11:8] : word[15:12];
        return DEFAULT_PALETTE[idx];
    endfunction

    // comparison process, samples on the falling edge where outputs are stable
    int px, line, reads_line, reads_frame, frame_idx, frame_err0;
    int last_hs_fall = -1;
    int hs_in_frame, hs_in_vsync, hs_periods, sync_errors, e0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    logic prev_vis = 1'b0;
    string frame_names [4] = '{"disabled frame", "enable held to frame boundary",
                               "text content and memory traffic", "disable again"};

    always @(negedge clk) begin
        if (!reset_i) begin
            if (visible_o) begin
                check_value("rgb", 32'({red_o, green_o, blue_o}), 32'(ref_color(px, line)));
                px++;
            end else begin
                check_value("rgb blank", 32'({red_o, green_o, blue_o}), 0);
            end
            if (frame_idx == 1 || frame_idx == 3) begin   // display off, memory left to blitter
                check_value("blit_cycle_o", 32'(blit_cycle_o), 1);
            end
            if (prev_vis && !visible_o) begin    // end of a visible line
                check_value("visible_o run", px, 64);
                check_value("vram reads per line", reads_line, 8);
                line++;
                px = 0;
                reads_line = 0;
            end
            if (vram_sel_o) begin
                check_value("vram_addr_o", 32'(vram_addr_o), (line / 8) * 8 + reads_line);
                reads_line++;
                reads_frame++;
            end
            if (prev_hs && !hsync_o) begin
                e0 = errors;
                if (last_hs_fall >= 0) begin
                    check_value("hsync period", cycles - last_hs_fall, LINE_CLKS);
                    hs_periods++;
                end
                sync_errors += errors - e0;
                last_hs_fall = cycles;
                hs_in_frame++;
                if (!vsync_o) hs_in_vsync++;
            end
            if (!prev_vs && vsync_o) begin
                e0 = errors;
                check_value("hsync pulses in vsync", hs_in_vsync, 2);
                sync_errors += errors - e0;
                hs_in_vsync = 0;
            end
            if (prev_vs && !vsync_o) begin       // vsync follows the visible lines of a frame
                e0 = errors;
                if (frame_idx > 0) check_value("hsync pulses per frame", hs_in_frame, 40);
                sync_errors += errors - e0;
                if (frame_idx < 4) begin
                    check_value("visible lines", line, (frame_idx == 2) ? 32 : 0);
                    check_value("vram reads per frame", reads_frame, (frame_idx == 2) ? 256 : 0);
                    report_test(frame_names[frame_idx], errors - frame_err0);
                end
                frame_idx++;
                frame_err0 = errors;
                hs_in_frame = 0;
                line = 0;
                px = 0;
                reads_line = 0;
                reads_frame = 0;
            end
            prev_hs = hsync_o;
            prev_vs = vsync_o;
            prev_vis = visible_o;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [15:0] v;
        reset_i = 1'b1;
        enable_i = 1'b0;
        for (int i = 0; i < 64; i++) begin
            v = take_bits(16);
            vram[i] = v;
        end
        for (int i = 0; i < 8192; i++) begin
            v = take_bits(8);
            font[i] = v[7:0];
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        cycles = 0;                              // counted from reset release
        repeat (FRAME_CLKS + FRAME_CLKS / 2) @(negedge clk);
        enable_i = 1'b1;                         // mid frame, takes hold one frame later
        repeat (FRAME_CLKS) @(negedge clk);
        enable_i = 1'b0;                         // mid enabled frame
        repeat (FRAME_CLKS + FRAME_CLKS / 2 + 8) @(negedge clk);

        check_value("frames seen", frame_idx, 4);
        check_value("hsync periods seen", 32'(hs_periods > 150), 1);
        report_test("sync timing", sync_errors);
        $display("done: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: video_gen.f
source/video_timing_pkg.sv
source/text_mode_pkg.sv
source/video_timing.sv
source/text_fetch.sv
source/pixel_out.sv
source/video_gen.sv
dv/video_gen_chk.sv
dv/video_gen_tb.sv

// File: Makefile
SRCS := $(shell cat video_gen.f)

.PHONY: run clean

run: obj_dir/Vvideo_gen_tb
	@out=$$(./obj_dir/Vvideo_gen_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '*** TEST PASSED ***'

obj_dir/V%: video_gen.f $(SRCS)
	verilator --binary --timing --assert --top-module $* -f video_gen.f

clean:
	rm -rf obj_dir
